/* Makefile */
# Verilator build and run of the rename and register file testbench.

VERILATOR ?= verilator
TOP ?= rename_regfile_tb
LOG ?= sim.log
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY := $(OBJ_DIR)/V$(TOP)

.PHONY: help test build clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench into $(LOG) and check it"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP LOG FILELIST OBJ_DIR VFLAGS"

build: $(BINARY)

$(BINARY): $(SOURCES) rf_consts.svh $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: build
	@./$(BINARY) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)."; exit 1; \
	fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)."; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* filelist.f */
+incdir+.
rf_pkg.sv
register_bank.sv
rename_table.sv
free_list.sv
ready_table.sv
rename_regfile.sv
tb_clock_gen.sv
rename_regfile_tb.sv

/* free_list.sv */
// Free physical register queue
`include "rf_consts.svh"

module free_list (
    input logic clk,
    input logic reset,

    // Allocation side. The head is consumed on pop.
    input logic pop,

    // Release side. The register is written at the tail.
    input logic push,
    input rf_pkg::phys_addr_t push_phys,

    output rf_pkg::phys_addr_t head_phys,
    output logic empty
);
    import rf_pkg::*;

    localparam int PTR_WIDTH = $clog2(FREE_DEPTH);
    localparam int COUNT_WIDTH = $clog2(FREE_DEPTH + 1);

    phys_addr_t entries [FREE_DEPTH]; // Queue storage.
    logic [PTR_WIDTH-1:0] head_ptr;   // Next register to hand out.
    logic [PTR_WIDTH-1:0] tail_ptr;   // Slot for the next released register.
    logic [COUNT_WIDTH-1:0] count;    // Registers currently free.
    logic full;

    assign full = (count == COUNT_WIDTH'(FREE_DEPTH));
    assign empty = (count == '0);
    assign head_phys = entries[head_ptr]; // Offered to rename in the same cycle.

    // Every register above the architectural range starts free, lowest first.
    // The queue is full after reset, so the tail sits on the head.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < FREE_DEPTH; i++) begin
                entries[i] <= phys_addr_t'(`RF_NUM_ARCH + i);
            end
        end else if (push) begin
            entries[tail_ptr] <= push_phys;
        end
    end

    // The depth is a power of two, so the pointers wrap on their own.
    // A push and a pop in the same cycle move both pointers and leave the count alone.
    always_ff @(posedge clk) begin
        if (reset) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count <= COUNT_WIDTH'(FREE_DEPTH);
        end else begin
            if (pop) head_ptr <= head_ptr + 1'b1;
            if (push) tail_ptr <= tail_ptr + 1'b1;
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Renaming while empty would hand out a register that is still live.
    pop_empty_assertion:
        assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
        else $error("Free list pop while empty.");

    // A push into a full queue means some register was released twice.
    // A pop in the same cycle frees the slot at the head.
    push_full_assertion:
        assert property (@(posedge clk) disable iff (reset) push |-> !full || pop)
        else $error("Free list push while full.");

endmodule

/* ready_table.sv */
// Physical register ready bits
`include "rf_consts.svh"

module ready_table (
    input logic clk,
    input logic reset,

    // A freshly allocated register has no value yet.
    input logic alloc_valid,
    input rf_pkg::phys_addr_t alloc_phys,

    // Writeback makes the value available.
    input logic wb_valid,
    input rf_pkg::phys_addr_t wb_phys,

    // Combinational status lookups.
    input rf_pkg::phys_addr_t query_phys [`RF_NUM_READ_PORTS],
    output logic query_ready [`RF_NUM_READ_PORTS]
);
    import rf_pkg::*;

    logic [`RF_NUM_PHYS-1:0] ready; // One bit per physical register.

    // The registers behind the reset map hold committed state and start ready.
    // Registers waiting in the free list start not ready.
    always_ff @(posedge clk) begin
        if (reset) begin
            ready <= {{(`RF_NUM_PHYS - `RF_NUM_ARCH){1'b0}}, {`RF_NUM_ARCH{1'b1}}};
        end else begin
            if (alloc_valid) ready[alloc_phys] <= 1'b0;
            if (wb_valid) ready[wb_phys] <= 1'b1; // Last assignment wins over allocation.
        end
    end

    always_comb begin
        for (int i = 0; i < `RF_NUM_READ_PORTS; i++) begin
            query_ready[i] = ready[query_phys[i]];
        end
    end

    // A writeback always targets a register that some rename made not ready.
    wb_target_assertion:
        assert property (@(posedge clk) disable iff (reset) wb_valid |-> !ready[wb_phys])
        else $error("Writeback to a register that is already ready.");

endmodule

/* register_bank.sv */
// Physical register bank
`include "rf_consts.svh"

module register_bank #(
    parameter int NUM_READ_PORTS = `RF_NUM_READ_PORTS
) (
    input logic clk,
    input logic reset,

    // Writeback port.
    input rf_pkg::phys_addr_t write_addr,
    input rf_pkg::reg_data_t new_data,
    input logic commit,

    // Operand read ports.
    input rf_pkg::phys_addr_t read_addr [NUM_READ_PORTS],
    output rf_pkg::reg_data_t data [NUM_READ_PORTS]
);
    import rf_pkg::*;

    reg_data_t bank [`RF_NUM_PHYS]; // One word per physical register.

    // The whole bank clears on reset so every register reads zero before its first write.
    // Physical register 0 carries x0 and is never written.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RF_NUM_PHYS; i++) begin
                bank[i] <= '0;
            end
        end else if (commit && write_addr != '0) begin
            bank[write_addr] <= new_data; // Visible to reads in the next cycle.
        end
    end

    // Reads are purely combinational.
    // There is no bypass from the write port in the same cycle.
    always_comb begin
        for (int i = 0; i < NUM_READ_PORTS; i++) begin
            data[i] = bank[read_addr[i]];
        end
    end

    // x0 maps to physical 0 forever, so a writeback there means the rename
    // logic handed out register 0 at some earlier point.
    write_to_zero_reg_assertion:
        assert property (@(posedge clk) disable iff (reset) commit |-> write_addr != '0)
        else $error("Writeback to physical register 0.");

endmodule

/* rename_regfile.sv */
// Rename and register file top
`include "rf_consts.svh"

module rename_regfile (
    input logic clk,
    input logic reset,

    // Rename request. One per cycle at most.
    input logic rename_valid,
    input rf_pkg::arch_addr_t rename_rs1,
    input rf_pkg::arch_addr_t rename_rs2,
    input rf_pkg::arch_addr_t rename_rd,

    // Rename results, valid in the request cycle.
    output rf_pkg::phys_addr_t rs1_phys,
    output rf_pkg::phys_addr_t rs2_phys,
    output rf_pkg::phys_addr_t rd_phys,
    output rf_pkg::phys_addr_t rd_prev_phys,

    // Writeback.
    input logic commit,
    input rf_pkg::phys_addr_t write_addr,
    input rf_pkg::reg_data_t new_data,

    // Release of a physical register that is no longer referenced.
    input logic release_valid,
    input rf_pkg::phys_addr_t release_phys,

    // Operand reads with ready status.
    input rf_pkg::phys_addr_t read_addr [`RF_NUM_READ_PORTS],
    output rf_pkg::reg_data_t read_data [`RF_NUM_READ_PORTS],
    output logic read_ready [`RF_NUM_READ_PORTS],

    output logic free_empty // The core holds renames while this is high.
);
    import rf_pkg::*;

    phys_addr_t free_head; // Register the next rename receives.

    assign rd_phys = free_head;

    register_bank #(
        .NUM_READ_PORTS(`RF_NUM_READ_PORTS)
    ) u_register_bank (
        .clk(clk), .reset(reset),
        .write_addr(write_addr), .new_data(new_data), .commit(commit),
        .read_addr(read_addr), .data(read_data)
    );

    rename_table u_rename_table (
        .clk(clk), .reset(reset),
        .rename_valid(rename_valid),
        .rs1(rename_rs1), .rs2(rename_rs2), .rd(rename_rd),
        .new_phys(free_head),
        .rs1_phys(rs1_phys), .rs2_phys(rs2_phys), .rd_prev_phys(rd_prev_phys)
    );

    // Each rename consumes the head. Each release refills the tail.
    free_list u_free_list (
        .clk(clk), .reset(reset),
        .pop(rename_valid),
        .push(release_valid), .push_phys(release_phys),
        .head_phys(free_head), .empty(free_empty)
    );

    // The allocated register goes not ready until its writeback.
    ready_table u_ready_table (
        .clk(clk), .reset(reset),
        .alloc_valid(rename_valid), .alloc_phys(free_head),
        .wb_valid(commit), .wb_phys(write_addr),
        .query_phys(read_addr), .query_ready(read_ready)
    );

    // A free register is never also the live mapping of the destination.
    // A failure points at a double release or a corrupt map.
    alloc_not_mapped_assertion:
        assert property (@(posedge clk) disable iff (reset)
            rename_valid |-> free_head != rd_prev_phys)
        else $error("Allocated register is still mapped.");

endmodule

/* rename_regfile_tb.sv */
// Rename and register file testbench
`include "rf_consts.svh"

module rename_regfile_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rf_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2; // Inputs change this long after the rising edge.
    localparam int CHECK_LEAD = 4;  // Outputs are sampled this long before the next edge.

    // Operation codes of the data file.
    localparam logic [1:0] OP_RENAME = 2'd0;
    localparam logic [1:0] OP_WRITEBACK = 2'd1;
    localparam logic [1:0] OP_RELEASE = 2'd2;
    localparam logic [1:0] OP_READ = 2'd3;

    // One line of the data file.
    typedef struct packed {
        logic [1:0] op;
        logic [31:0] count;          // Repetitions, with addresses stepped by one each time.
        logic [4:0][31:0] stim;
        logic [4:0][31:0] expected;
    } op_entry_t;

    logic clk;
    logic reset;
    logic rename_valid;
    arch_addr_t rename_rs1;
    arch_addr_t rename_rs2;
    arch_addr_t rename_rd;
    phys_addr_t rs1_phys;
    phys_addr_t rs2_phys;
    phys_addr_t rd_phys;
    phys_addr_t rd_prev_phys;
    logic commit;
    phys_addr_t write_addr;
    reg_data_t new_data;
    logic release_valid;
    phys_addr_t release_phys;
    phys_addr_t read_addr [`RF_NUM_READ_PORTS];
    reg_data_t read_data [`RF_NUM_READ_PORTS];
    logic read_ready [`RF_NUM_READ_PORTS];
    logic free_empty;

    op_entry_t ops [$];        // Operations in file order.
    int total_ops = 0;         // Operations after repetition, for the watchdog.
    bit load_done = 1'b0;
    logic [31:0] rng_state = 32'd52;

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(2)) u_clock_gen (
        .clk(clk),
        .reset(reset)
    );

    rename_regfile u_rename_regfile (
        .clk(clk), .reset(reset),
        .rename_valid(rename_valid),
        .rename_rs1(rename_rs1), .rename_rs2(rename_rs2), .rename_rd(rename_rd),
        .rs1_phys(rs1_phys), .rs2_phys(rs2_phys),
        .rd_phys(rd_phys), .rd_prev_phys(rd_prev_phys),
        .commit(commit), .write_addr(write_addr), .new_data(new_data),
        .release_valid(release_valid), .release_phys(release_phys),
        .read_addr(read_addr), .read_data(read_data), .read_ready(read_ready),
        .free_empty(free_empty)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stop_with_error(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with_error($sformatf("mismatch %s: got 0x%08h, expected 0x%08h",
                                      name, actual, expected));
        end
    endtask

    // Lines starting with # are comments. Every other line has twelve fields.
    task automatic load_operations();
        int fd;
        int fields;
        string line;
        string op_word;
        logic [31:0] count;
        logic [31:0] field [10];
        op_entry_t entry;
        fd = $fopen("rename_regfile_testdata.txt", "r");
        if (fd == 0) stop_with_error("Cannot open rename_regfile_testdata.txt for reading.");
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line.getc(0) == "#") continue;
            fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h", op_word, count,
                             field[0], field[1], field[2], field[3], field[4],
                             field[5], field[6], field[7], field[8], field[9]);
            if (fields != 12) stop_with_error($sformatf("Malformed data line: %s", line));
            if (op_word == "rename") entry.op = OP_RENAME;
            else if (op_word == "writeback") entry.op = OP_WRITEBACK;
            else if (op_word == "release") entry.op = OP_RELEASE;
            else if (op_word == "read") entry.op = OP_READ;
            else stop_with_error($sformatf("Unknown operation in data line: %s", line));
            entry.count = count;
            for (int j = 0; j < 5; j++) begin
                entry.stim[j] = field[j];
                entry.expected[j] = field[j + 5];
            end
            ops.push_back(entry);
            total_ops += int'(count);
        end
        $fclose(fd);
        if (ops.size() == 0) stop_with_error("The data file holds no operations.");
    endtask

    // Zero to three quiet cycles. State moves only on strobes, so expectations hold.
    task automatic insert_idle_cycles();
        int idle;
        rng_state = xorshift32(rng_state);
        idle = int'(rng_state % 32'd4);
        repeat (idle) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    // Called at the drive point of a cycle. Returns at the drive point of the next one.
    task automatic run_operation(input op_entry_t entry, input int step);
        logic [31:0] offset;
        offset = 32'(step);
        case (entry.op)
            OP_RENAME: begin
                rename_valid = 1'b1;
                rename_rs1 = arch_addr_t'(entry.stim[0]);
                rename_rs2 = arch_addr_t'(entry.stim[1]);
                rename_rd = arch_addr_t'(entry.stim[2] + offset);
                release_valid = entry.stim[3][0]; // Optional release in the same cycle.
                release_phys = phys_addr_t'(entry.stim[4]);
            end
            OP_WRITEBACK: begin
                commit = 1'b1;
                write_addr = phys_addr_t'(entry.stim[0] + offset);
                new_data = entry.stim[1];
            end
            OP_RELEASE: begin
                release_valid = 1'b1;
                release_phys = phys_addr_t'(entry.stim[0] + offset);
            end
            default: begin
                read_addr[0] = phys_addr_t'(entry.stim[0] + offset);
                read_addr[1] = phys_addr_t'(entry.stim[1] + offset);
            end
        endcase
        #(CLK_PERIOD - DRIVE_DELAY - CHECK_LEAD);
        if (entry.op == OP_RENAME) begin
            compare_value("rs1_phys", 32'(rs1_phys), entry.expected[0]);
            compare_value("rs2_phys", 32'(rs2_phys), entry.expected[1]);
            compare_value("rd_phys", 32'(rd_phys), entry.expected[2] + offset);
            compare_value("rd_prev_phys", 32'(rd_prev_phys), entry.expected[3] + offset);
        end else if (entry.op == OP_READ) begin
            compare_value("read_data[0]", read_data[0], entry.expected[0]);
            compare_value("read_data[1]", read_data[1], entry.expected[1]);
            compare_value("read_ready[0]", 32'(read_ready[0]), entry.expected[2]);
            compare_value("read_ready[1]", 32'(read_ready[1]), entry.expected[3]);
        end
        compare_value("free_empty", 32'(free_empty), entry.expected[4]); // State before the edge.
        @(posedge clk);
        #DRIVE_DELAY;
        rename_valid = 1'b0;
        commit = 1'b0;
        release_valid = 1'b0;
    endtask

    initial begin
        rename_valid = 1'b0;
        rename_rs1 = '0;
        rename_rs2 = '0;
        rename_rd = '0;
        commit = 1'b0;
        write_addr = '0;
        new_data = '0;
        release_valid = 1'b0;
        release_phys = '0;
        read_addr[0] = '0;
        read_addr[1] = '0;
        load_operations();
        load_done = 1'b1;
        wait (reset === 1'b0); // Released at the drive point after the second edge.
        for (int i = 0; i < ops.size(); i++) begin
            for (int k = 0; k < int'(ops[i].count); k++) begin
                insert_idle_cycles();
                run_operation(ops[i], k);
            end
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

    // Each operation takes at most four cycles including idle ones.
    initial begin
        wait (load_done);
        #(CLK_PERIOD * (5 * total_ops + 20));
        stop_with_error($sformatf("Watchdog expired after %0d operations were scheduled.",
                                  total_ops));
    end

endmodule

/* rename_regfile_testdata.txt */
# Columns: op count s0 s1 s2 s3 s4 e0 e1 e2 e3 e4, all hex, e4 is free_empty before the edge.
# rename s=rs1 rs2 rd rel_valid rel_phys e=rs1_phys rs2_phys rd_phys rd_prev_phys. read s=addr0 addr1 e=data0 data1 ready0 ready1.
# Reset state, ports sweep 0..1f and 20..3f
read 20 00 20 0 0 0 0 0 1 0 0
# Allocation in order, a source equal to rd sees the old mapping
rename 1 01 02 03 0 00 01 02 20 03 0
rename 1 03 03 03 0 00 20 20 21 20 0
rename 1 03 04 04 0 00 21 04 22 04 0
rename 1 04 00 05 0 00 22 00 23 05 0
# Writeback then read back
read 1 21 22 0 0 0 0 0 0 0 0
writeback 1 21 deadbeef 0 0 0 0 0 0 0 0
read 1 21 22 0 0 0 deadbeef 0 1 0 0
writeback 1 22 12345678 0 0 0 0 0 0 0 0
read 1 22 03 0 0 0 12345678 0 1 1 0
writeback 1 20 a5a5a5a5 0 0 0 0 0 0 0 0
read 1 20 23 0 0 0 a5a5a5a5 0 1 0 0
rename 1 03 05 04 0 00 21 23 24 22 0
rename 1 04 03 05 0 00 24 21 25 23 0
# Drain the rest of the free list with x6..x31
rename 1a 01 02 06 0 00 01 02 26 06 0
read 1 3f 26 0 0 0 0 0 0 0 1
# Release recycling
release 1 23 0 0 0 0 0 0 0 0 1
read 1 23 00 0 0 0 0 0 0 1 0
rename 1 05 06 07 0 00 25 26 23 27 0
read 1 01 02 0 0 0 0 0 1 1 1
# Release and rename in the same cycle
release 1 22 0 0 0 0 0 0 0 0 1
release 1 27 0 0 0 0 0 0 0 0 0
read 1 22 27 0 0 0 12345678 0 1 0 0
rename 1 03 07 08 1 20 21 23 22 28 0
read 1 22 20 0 0 0 12345678 a5a5a5a5 0 1 0
rename 1 08 00 09 0 00 22 00 27 29 0
rename 1 09 08 0a 0 00 27 22 20 2a 0
read 1 00 01 0 0 0 0 0 1 1 1
writeback 1 20 0badf00d 0 0 0 0 0 0 0 1
read 1 20 27 0 0 0 0badf00d 0 1 0 1

/* rename_table.sv */
// Architectural register map
`include "rf_consts.svh"

module rename_table (
    input logic clk,
    input logic reset,

    // Rename request.
    input logic rename_valid,
    input rf_pkg::arch_addr_t rs1,
    input rf_pkg::arch_addr_t rs2,
    input rf_pkg::arch_addr_t rd,
    input rf_pkg::phys_addr_t new_phys, // Register allocated to rd by the free list.

    // Lookup results.
    output rf_pkg::phys_addr_t rs1_phys,
    output rf_pkg::phys_addr_t rs2_phys,
    output rf_pkg::phys_addr_t rd_prev_phys
);
    import rf_pkg::*;

    phys_addr_t map [`RF_NUM_ARCH]; // Current physical home of each architectural register.

    // After reset architectural register i lives in physical register i.
    // A rename moves rd to the newly allocated register at the edge.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RF_NUM_ARCH; i++) begin
                map[i] <= phys_addr_t'(i);
            end
        end else if (rename_valid) begin
            map[rd] <= new_phys;
        end
    end

    // Lookups read the map as it stood before this rename.
    // So a source that names rd still sees the old mapping, which is what the
    // instruction needs because it reads rd before writing it.
    assign rs1_phys = map[rs1];
    assign rs2_phys = map[rs2];

    // The old mapping of rd goes back to the core.
    // It is released once the renaming instruction retires.
    assign rd_prev_phys = map[rd];

    // x0 must stay bound to physical 0. A rename of x0 would also pull a
    // register from the free list that is never returned.
    rename_x0_assertion:
        assert property (@(posedge clk) disable iff (reset) rename_valid |-> rd != '0)
        else $error("Rename with x0 as destination.");

endmodule

/* rf_consts.svh */
// Register file constants
`ifndef RF_CONSTS_SVH
`define RF_CONSTS_SVH

// Physical registers held in the bank. Must be a power of two.
`define RF_NUM_PHYS 64

// Architectural registers of the RV32I integer file.
`define RF_NUM_ARCH 32

// Width of one register value in bits.
`define RF_DATA_WIDTH 32

// Read ports offered at the top level for operand fetch.
`define RF_NUM_READ_PORTS 2

`endif

/* rf_pkg.sv */
// Register file types
`include "rf_consts.svh"

package rf_pkg;

    // Index into the physical register bank (6 bits for 64 entries).
    typedef logic [$clog2(`RF_NUM_PHYS)-1:0] phys_addr_t;

    // Index into the architectural register file (5 bits for x0 to x31).
    typedef logic [$clog2(`RF_NUM_ARCH)-1:0] arch_addr_t;

    // One register value.
    typedef logic [`RF_DATA_WIDTH-1:0] reg_data_t;

    // The map and the free list together cover every physical register,
    // so the free list depth follows from the two counts.
    localparam int FREE_DEPTH = `RF_NUM_PHYS - `RF_NUM_ARCH;

endpackage

/* tb_clock_gen.sv */
// Testbench clock and reset
module tb_clock_gen #(
    parameter int PERIOD = 40,      // Clock period in ns.
    parameter int RESET_CYCLES = 2  // Rising edges seen with reset high.
) (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk; // First rising edge at half a period.
    end

    // Reset drops shortly after an edge, in step with the other inputs.
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 reset = 1'b0;
    end

endmodule
